// File: source/host_link_cfg.svh
`ifndef HOST_LINK_CFG_SVH
`define HOST_LINK_CFG_SVH

// widths
`define CMD_W        8
`define MEM_ADDR_W   8    // 256 words on chip
`define HOST_ADDR_W  24   // three staged address bytes
`define WORD_W       16

// words summed per block checksum
`define BLOCK_WORDS  16

// host command codes
`define CMD_SET_DAT0   8'h10
`define CMD_SET_DAT1   8'h11
`define CMD_SET_ADR0   8'h12
`define CMD_SET_ADR1   8'h13
`define CMD_SET_ADR2   8'h14
`define CMD_WORD_WR    8'hA0
`define CMD_WORD_RD    8'hA1
`define CMD_BLOCK_SUM  8'hA3

// flow control
`define CMD_CREDITS    1    // held by the frame receiver
`define REPLY_CREDITS  1    // held by the executor

`endif

// File: source/host_link_pkg.sv
`include "host_link_cfg.svh"

package host_link_pkg;

  typedef logic [`CMD_W-1:0]       cmd_t;        // command byte of a host frame
  typedef logic [7:0]              byte_t;       // data byte of a host frame
  typedef logic [`WORD_W-1:0]      word_t;       // memory word
  typedef logic [`MEM_ADDR_W-1:0]  mem_addr_t;   // on-chip word address
  typedef logic [`HOST_ADDR_W-1:0] host_addr_t;  // staged host address

  // command executor FSM
  typedef enum logic [2:0] {
    st_idle,
    st_decode,
    st_word_access,  // req held until granted
    st_wait_read,
    st_wait_sum,
    st_reply         // parked here without a reply credit
  } exec_state_t;

endpackage

// File: source/mem_port_if.sv
`timescale 1ns/100ps

interface mem_port_if
  import host_link_pkg::*;
;

  logic      req;     // held until gnt
  logic      we;
  mem_addr_t addr;
  word_t     wdata;
  logic      gnt;     // write done at grant
  word_t     rdata;
  logic      rvalid;  // one cycle after a read grant

  modport peer (
    output req, we, addr, wdata,
    input  gnt, rdata, rvalid
  );

  modport arbiter (
    input  req, we, addr, wdata,
    output gnt, rdata, rvalid
  );

endinterface

// File: source/link_frame_rx.sv
`timescale 1ns/100ps
`include "host_link_cfg.svh"

module link_frame_rx
  import host_link_pkg::*;
(
  input  logic  sys_clk,
  input  logic  sys_rst_n,
  input  logic  link_clk,
  input  logic  link_bit,
  output logic  bit_tick,
  output logic  frame_valid,
  output cmd_t  frame_cmd,
  output byte_t frame_dat,
  input  logic  cmd_credit
);

  localparam int cr_w     = $clog2(`CMD_CREDITS + 1);
  localparam int last_bit = `CMD_W + 8;  // count of the final data bit

  logic [1:0]      sync_q1;  // {strobe, bit}
  logic [1:0]      sync_q2;
  logic            clk_q3;   // delayed strobe for edge detect
  logic [4:0]      bit_cnt;  // 0 while waiting for a start bit
  logic [cr_w-1:0] credits;
  logic            spend;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
      clk_q3  <= 1'b0;
    end else begin
      sync_q1 <= {link_clk, link_bit};
      sync_q2 <= sync_q1;
      clk_q3  <= sync_q2[1];
    end
  end

  assign bit_tick = sync_q2[1] & ~clk_q3;
  assign spend    = bit_tick && (bit_cnt == 5'(last_bit));

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      bit_cnt     <= '0;
      frame_valid <= 1'b0;
      credits     <= cr_w'(`CMD_CREDITS);
    end else begin
      frame_valid <= 1'b0;
      if (bit_tick) begin
        if (bit_cnt == '0) begin
          if (sync_q2[0] && credits != '0)  // start bits ignored without credit
            bit_cnt <= 5'd1;
        end else if (bit_cnt == 5'(last_bit)) begin
          bit_cnt     <= '0;
          frame_valid <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
      case ({spend, cmd_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // both fields shift in lsb first from the top
  always_ff @(posedge sys_clk) begin
    if (bit_tick && bit_cnt != '0) begin
      if (bit_cnt <= 5'(`CMD_W))
        frame_cmd <= {sync_q2[0], frame_cmd[`CMD_W-1:1]};
      else
        frame_dat <= {sync_q2[0], frame_dat[7:1]};
    end
  end

endmodule

// File: source/link_frame_tx.sv
`timescale 1ns/100ps
`include "host_link_cfg.svh"

module link_frame_tx
  import host_link_pkg::*;
(
  input  logic  sys_clk,
  input  logic  sys_rst_n,
  input  logic  bit_tick,
  input  logic  reply_valid,
  input  word_t reply_word,
  output logic  reply_credit,
  output logic  reply_bit
);

  localparam int stop_idx = `WORD_W + 1;  // stop bit slot
  localparam int done_idx = `WORD_W + 2;  // stop bit has been on the line

  logic       active;
  logic [4:0] bit_cnt;
  word_t      tx_shift;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      active       <= 1'b0;
      bit_cnt      <= '0;
      reply_bit    <= 1'b0;
      reply_credit <= 1'b0;
    end else begin
      reply_credit <= 1'b0;
      if (!active) begin
        if (reply_valid) begin
          active  <= 1'b1;
          bit_cnt <= '0;
        end
      end else if (bit_tick) begin
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt == '0) begin
          reply_bit <= 1'b1;  // start
        end else if (bit_cnt < 5'(stop_idx)) begin
          reply_bit <= tx_shift[0];
        end else if (bit_cnt == 5'(stop_idx)) begin
          reply_bit <= 1'b0;
        end else if (bit_cnt == 5'(done_idx)) begin
          reply_credit <= 1'b1;  // hand the credit back
          active       <= 1'b0;
        end
      end
    end
  end

  // low byte goes out first
  always_ff @(posedge sys_clk) begin
    if (!active && reply_valid)
      tx_shift <= reply_word;
    else if (active && bit_tick && bit_cnt != '0 && bit_cnt < 5'(stop_idx))
      tx_shift <= tx_shift >> 1;
  end

endmodule

// File: source/cmd_executor.sv
`timescale 1ns/100ps
`include "host_link_cfg.svh"

module cmd_executor
  import host_link_pkg::*;
(
  input  logic        sys_clk,
  input  logic        sys_rst_n,
  input  logic        frame_valid,
  input  cmd_t        frame_cmd,
  input  byte_t       frame_dat,
  output logic        cmd_credit,
  output logic        busy,
  mem_port_if.peer    mem,
  output logic        sum_start,
  output mem_addr_t   sum_base,
  input  logic        sum_done,
  input  word_t       sum_value,
  output logic        reply_valid,
  output word_t       reply_word,
  input  logic        reply_credit
);

  localparam int rc_w = $clog2(`REPLY_CREDITS + 1);

  exec_state_t     state;
  cmd_t            cmd_q;
  byte_t           dat_q;
  byte_t           dat0;
  byte_t           dat1;
  host_addr_t      host_addr;
  logic [rc_w-1:0] rpl_credits;
  logic            rpl_spend;

  assign busy      = (state != st_idle);
  assign rpl_spend = (state == st_reply) && (rpl_credits != '0);

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state       <= st_idle;
      cmd_credit  <= 1'b0;
      mem.req     <= 1'b0;
      sum_start   <= 1'b0;
      reply_valid <= 1'b0;
    end else begin
      cmd_credit  <= 1'b0;
      sum_start   <= 1'b0;
      reply_valid <= 1'b0;
      case (state)
        st_idle: if (frame_valid) state <= st_decode;
        st_decode: begin
          case (cmd_q)
            `CMD_WORD_WR, `CMD_WORD_RD: begin
              mem.req <= 1'b1;
              state   <= st_word_access;
            end
            `CMD_BLOCK_SUM: begin
              sum_start <= 1'b1;
              state     <= st_wait_sum;
            end
            default: begin  // staging loads and unknown codes
              cmd_credit <= 1'b1;
              state      <= st_idle;
            end
          endcase
        end
        st_word_access: begin
          if (mem.gnt) begin
            mem.req <= 1'b0;
            if (mem.we) begin
              cmd_credit <= 1'b1;
              state      <= st_idle;
            end else begin
              state <= st_wait_read;
            end
          end
        end
        st_wait_read: if (mem.rvalid) state <= st_reply;
        st_wait_sum:  if (sum_done) state <= st_reply;
        st_reply: begin
          if (rpl_spend) begin
            reply_valid <= 1'b1;
            cmd_credit  <= 1'b1;
            state       <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n)
      rpl_credits <= rc_w'(`REPLY_CREDITS);
    else if (rpl_spend && !reply_credit)
      rpl_credits <= rpl_credits - 1'b1;
    else if (!rpl_spend && reply_credit)
      rpl_credits <= rpl_credits + 1'b1;
  end

  always_ff @(posedge sys_clk) begin
    if (state == st_idle && frame_valid) begin
      cmd_q <= frame_cmd;
      dat_q <= frame_dat;
    end
    if (state == st_decode) begin
      case (cmd_q)
        `CMD_SET_DAT0: dat0              <= dat_q;
        `CMD_SET_DAT1: dat1              <= dat_q;
        `CMD_SET_ADR0: host_addr[7:0]   <= dat_q;
        `CMD_SET_ADR1: host_addr[15:8]  <= dat_q;
        `CMD_SET_ADR2: host_addr[23:16] <= dat_q;
        default: ;
      endcase
      mem.we    <= (cmd_q == `CMD_WORD_WR);
      mem.addr  <= host_addr[`MEM_ADDR_W-1:0];  // upper address bytes unused
      mem.wdata <= {dat1, dat0};
      sum_base  <= host_addr[`MEM_ADDR_W-1:0];
    end
    if (state == st_wait_read && mem.rvalid)
      reply_word <= mem.rdata;
    else if (state == st_wait_sum && sum_done)
      reply_word <= sum_value;
  end

endmodule

// File: source/block_checksum.sv
`timescale 1ns/100ps
`include "host_link_cfg.svh"

module block_checksum
  import host_link_pkg::*;
(
  input  logic      sys_clk,
  input  logic      sys_rst_n,
  input  logic      sum_start,
  input  mem_addr_t sum_base,
  output logic      sum_done,
  output word_t     sum_value,
  mem_port_if.peer  mem
);

  localparam int cnt_w = $clog2(`BLOCK_WORDS) + 1;
  localparam logic [cnt_w-1:0] last_idx = cnt_w'(`BLOCK_WORDS - 1);

  logic             active;
  logic [cnt_w-1:0] issue_cnt;  // grants taken
  logic [cnt_w-1:0] ret_cnt;    // words returned

  assign mem.we    = 1'b0;  // read only peer
  assign mem.wdata = '0;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      active    <= 1'b0;
      mem.req   <= 1'b0;
      issue_cnt <= '0;
      ret_cnt   <= '0;
      sum_done  <= 1'b0;
    end else begin
      sum_done <= 1'b0;
      if (sum_start && !active) begin
        active    <= 1'b1;
        mem.req   <= 1'b1;
        issue_cnt <= '0;
        ret_cnt   <= '0;
      end else if (active) begin
        if (mem.req && mem.gnt) begin
          issue_cnt <= issue_cnt + 1'b1;
          if (issue_cnt == last_idx) mem.req <= 1'b0;
        end
        if (mem.rvalid) begin  // reads overlap with new requests
          ret_cnt <= ret_cnt + 1'b1;
          if (ret_cnt == last_idx) begin
            active   <= 1'b0;
            sum_done <= 1'b1;
          end
        end
      end
    end
  end

  // address wraps at the top of memory by width
  always_ff @(posedge sys_clk) begin
    if (sum_start && !active) begin
      mem.addr  <= sum_base;
      sum_value <= '0;
    end else begin
      if (mem.req && mem.gnt) mem.addr <= mem.addr + 1'b1;
      if (mem.rvalid) sum_value <= sum_value + mem.rdata;
    end
  end

endmodule

// File: source/mem_arbiter.sv
`timescale 1ns/100ps

module mem_arbiter
  import host_link_pkg::*;
(
  input  logic        sys_clk,
  input  logic        sys_rst_n,
  mem_port_if.arbiter exec_port,
  mem_port_if.arbiter sum_port,
  output logic        ram_we,
  output mem_addr_t   ram_addr,
  output word_t       ram_wdata,
  input  word_t       ram_rdata
);

  // executor has priority over the checksum engine
  assign exec_port.gnt = exec_port.req;
  assign sum_port.gnt  = sum_port.req & ~exec_port.req;

  assign ram_we = (exec_port.gnt & exec_port.we) | (sum_port.gnt & sum_port.we);

  always_comb begin
    if (exec_port.req) begin
      ram_addr  = exec_port.addr;
      ram_wdata = exec_port.wdata;
    end else begin
      ram_addr  = sum_port.addr;
      ram_wdata = sum_port.wdata;
    end
  end

  // rvalid marks the owner of the shared ram output
  assign exec_port.rdata = ram_rdata;
  assign sum_port.rdata  = ram_rdata;

  // rvalid follows a read grant by one cycle
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      exec_port.rvalid <= 1'b0;
      sum_port.rvalid  <= 1'b0;
    end else begin
      exec_port.rvalid <= exec_port.gnt & ~exec_port.we;
      sum_port.rvalid  <= sum_port.gnt & ~sum_port.we;
    end
  end

endmodule

// File: source/word_ram.sv
`timescale 1ns/100ps
`include "host_link_cfg.svh"

module word_ram
  import host_link_pkg::*;
(
  input  logic      sys_clk,
  input  logic      we,
  input  mem_addr_t addr,
  input  word_t     wdata,
  output word_t     rdata
);

  localparam int depth = 2 ** `MEM_ADDR_W;

  word_t mem [depth];

  always_ff @(posedge sys_clk) begin
    if (we)
      mem[addr] <= wdata;
    rdata <= mem[addr];  // old data on a write cycle
  end

endmodule

// File: source/host_link_top.sv
`timescale 1ns/100ps

module host_link_top
  import host_link_pkg::*;
(
  input  logic sys_clk,
  input  logic sys_rst_n,
  input  logic link_clk,
  input  logic link_bit,
  output logic reply_bit,
  output logic busy
);

  logic      bit_tick;
  logic      frame_valid;
  cmd_t      frame_cmd;
  byte_t     frame_dat;
  logic      cmd_credit;
  logic      sum_start;
  mem_addr_t sum_base;
  logic      sum_done;
  word_t     sum_value;
  logic      reply_valid;
  word_t     reply_word;
  logic      reply_credit;
  logic      ram_we;
  mem_addr_t ram_addr;
  word_t     ram_wdata;
  word_t     ram_rdata;

  mem_port_if exec_mem ();
  mem_port_if sum_mem ();

  link_frame_rx u_rx (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .link_clk    (link_clk),
    .link_bit    (link_bit),
    .bit_tick    (bit_tick),
    .frame_valid (frame_valid),
    .frame_cmd   (frame_cmd),
    .frame_dat   (frame_dat),
    .cmd_credit  (cmd_credit)
  );

  cmd_executor u_exec (
    .sys_clk      (sys_clk),
    .sys_rst_n    (sys_rst_n),
    .frame_valid  (frame_valid),
    .frame_cmd    (frame_cmd),
    .frame_dat    (frame_dat),
    .cmd_credit   (cmd_credit),
    .busy         (busy),
    .mem          (exec_mem.peer),
    .sum_start    (sum_start),
    .sum_base     (sum_base),
    .sum_done     (sum_done),
    .sum_value    (sum_value),
    .reply_valid  (reply_valid),
    .reply_word   (reply_word),
    .reply_credit (reply_credit)
  );

  link_frame_tx u_tx (
    .sys_clk      (sys_clk),
    .sys_rst_n    (sys_rst_n),
    .bit_tick     (bit_tick),  // shares the rx strobe synchronizer
    .reply_valid  (reply_valid),
    .reply_word   (reply_word),
    .reply_credit (reply_credit),
    .reply_bit    (reply_bit)
  );

  block_checksum u_sum (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .sum_start (sum_start),
    .sum_base  (sum_base),
    .sum_done  (sum_done),
    .sum_value (sum_value),
    .mem       (sum_mem.peer)
  );

  mem_arbiter u_arb (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .exec_port (exec_mem.arbiter),
    .sum_port  (sum_mem.arbiter),
    .ram_we    (ram_we),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_rdata (ram_rdata)
  );

  word_ram u_ram (
    .sys_clk (sys_clk),
    .we      (ram_we),
    .addr    (ram_addr),
    .wdata   (ram_wdata),
    .rdata   (ram_rdata)
  );

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int period_ns    = 10,
  parameter int reset_cycles = 8
) (
  output logic sys_clk,
  output logic sys_rst_n
);

  initial begin
    sys_clk = 1'b0;
    forever #(period_ns / 2.0) sys_clk = ~sys_clk;
  end

  initial begin
    sys_rst_n = 1'b0;
    repeat (reset_cycles) @(posedge sys_clk);
    #1 sys_rst_n = 1'b1;  // released off the edge
  end

endmodule

// File: tests/tb_host_link.sv
`timescale 1ns/100ps
`include "host_link_cfg.svh"

module tb_host_link
  import host_link_pkg::*;
;

  localparam int row_cycles = 400;  // worst frame, sum, reply and quiet time
  localparam int reply_wait = 120;
  localparam int quiet_wait = 100;

  logic  sys_clk, sys_rst_n, link_clk, link_bit, reply_bit, busy;
  int    link_phase, rx_cnt, pass_cnt, fail_cnt;
  bit    table_ready;
  logic  bit_q[$];     // host bits waiting for the link
  word_t reply_q[$];   // decoded reply frames
  word_t rx_word;
  byte_t row_cmd[$], row_dat[$];
  bit    row_rpl[$];
  word_t row_exp[$];
  int    row_grp[$];
  word_t model_mem[256];
  byte_t m_dat0, m_dat1, m_adr;
  string grp_name[4] = '{"word write and read back", "random write and read back",
                         "block checksum", "unknown and staging commands"};

  tb_clock_gen #(.period_ns(10), .reset_cycles(8)) u_clk (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n)
  );

  host_link_top uut (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .link_clk  (link_clk),
    .link_bit  (link_bit),
    .reply_bit (reply_bit),
    .busy      (busy)
  );

  // link strobe at a quarter of sys_clk with data set one cycle before the rise
  always @(posedge sys_clk) begin
    #1;
    link_phase = (link_phase + 1) % 4;
    if (link_phase == 1)
      link_bit = (bit_q.size() > 0) ? bit_q.pop_front() : 1'b0;
    link_clk = (link_phase >= 2);
  end

  // rebuild reply frames from start, 16 bits lsb first and stop
  always @(posedge link_clk) begin
    if (rx_cnt == 0) begin
      if (reply_bit === 1'b1) rx_cnt = 1;
    end else if (rx_cnt <= 16) begin
      rx_word[rx_cnt-1] = reply_bit;
      rx_cnt = rx_cnt + 1;
    end else begin
      if (reply_bit !== 1'b0) begin
        $display("reply frame ending at %0t has no stop bit", $time);
        fail_cnt++;
      end
      reply_q.push_back(rx_word);
      rx_cnt = 0;
    end
  end

  function automatic word_t block_sum(byte_t base);
    word_t acc;
    acc = '0;
    for (int k = 0; k < `BLOCK_WORDS; k++)
      acc = acc + model_mem[byte_t'(base + k)];  // wraps at 255
    return acc;
  endfunction

  // adds one table row with the reply the host command rules predict
  function automatic void add_cmd(byte_t cmd, byte_t dat, int grp);
    bit    rpl;
    word_t exp;
    rpl = 1'b0;
    exp = '0;
    case (cmd)
      `CMD_SET_DAT0:  m_dat0 = dat;
      `CMD_SET_DAT1:  m_dat1 = dat;
      `CMD_SET_ADR0:  m_adr  = dat;  // only the low byte reaches memory
      `CMD_WORD_WR:   model_mem[m_adr] = {m_dat1, m_dat0};
      `CMD_WORD_RD: begin
        rpl = 1'b1;
        exp = model_mem[m_adr];
      end
      `CMD_BLOCK_SUM: begin
        rpl = 1'b1;
        exp = block_sum(m_adr);
      end
      default: ;
    endcase
    row_cmd.push_back(cmd);
    row_dat.push_back(dat);
    row_rpl.push_back(rpl);
    row_exp.push_back(exp);
    row_grp.push_back(grp);
  endfunction

  function automatic void write_word(byte_t addr, word_t w, int grp);
    add_cmd(`CMD_SET_ADR0, addr, grp);
    add_cmd(`CMD_SET_DAT0, w[7:0], grp);
    add_cmd(`CMD_SET_DAT1, w[15:8], grp);
    add_cmd(`CMD_WORD_WR, 8'h00, grp);
  endfunction

  function automatic void read_word(byte_t addr, int grp);
    add_cmd(`CMD_SET_ADR0, addr, grp);
    add_cmd(`CMD_WORD_RD, 8'h00, grp);
  endfunction

  function automatic void build_table();
    byte_t addrs[6];
    byte_t a, base;
    bit    dup;
    add_cmd(`CMD_SET_ADR2, 8'h7e, 0);
    add_cmd(`CMD_SET_ADR1, 8'h3c, 0);
    add_cmd(`CMD_SET_ADR0, 8'h42, 0);
    add_cmd(`CMD_SET_DAT0, 8'hcd, 0);
    add_cmd(`CMD_SET_DAT1, 8'hab, 0);
    add_cmd(`CMD_WORD_WR, 8'h00, 0);
    add_cmd(`CMD_WORD_RD, 8'h00, 0);
    for (int k = 0; k < 6; k++) begin
      do begin
        a   = byte_t'($urandom);
        dup = 1'b0;
        for (int j = 0; j < k; j++)
          if (addrs[j] == a) dup = 1'b1;
      end while (dup);
      addrs[k] = a;
      write_word(a, word_t'($urandom), 1);
    end
    for (int k = 5; k >= 0; k--) read_word(addrs[k], 1);  // reverse order
    base = byte_t'(8'h10 + ($urandom % 192));
    for (int k = 0; k < `BLOCK_WORDS; k++) write_word(byte_t'(base + k), word_t'($urandom), 2);
    add_cmd(`CMD_SET_ADR0, base, 2);
    add_cmd(`CMD_BLOCK_SUM, 8'h00, 2);
    base = 8'hf8;  // block runs past the top of memory
    for (int k = 0; k < `BLOCK_WORDS; k++) write_word(byte_t'(base + k), word_t'($urandom), 2);
    add_cmd(`CMD_SET_ADR0, base, 2);
    add_cmd(`CMD_BLOCK_SUM, 8'h00, 2);
    add_cmd(8'h00, 8'h99, 3);
    add_cmd(8'ha2, 8'h01, 3);
    add_cmd(8'hff, 8'hff, 3);
    add_cmd(`CMD_SET_DAT0, 8'h11, 3);
    add_cmd(`CMD_SET_DAT1, 8'h22, 3);
    add_cmd(`CMD_SET_ADR1, 8'h5a, 3);
    add_cmd(`CMD_SET_ADR2, 8'hc3, 3);
    add_cmd(`CMD_WORD_RD, 8'h00, 3);  // low address byte still staged at 0xf8
    read_word(addrs[0], 3);
    read_word(8'h42, 3);
  endfunction

  task automatic send_frame(byte_t cmd, byte_t dat);
    bit_q.push_back(1'b1);  // start
    for (int k = 0; k < 8; k++) bit_q.push_back(cmd[k]);
    for (int k = 0; k < 8; k++) bit_q.push_back(dat[k]);
    while (bit_q.size() > 0) @(negedge sys_clk);
  endtask

  task automatic wait_busy(logic level, int limit, output bit ok);
    int n;
    n  = 0;
    ok = 1'b0;
    while (!ok && n < limit) begin
      @(negedge sys_clk);
      ok = (busy === level);
      n++;
    end
  endtask

  task automatic apply_row(int i);
    bit    ok;
    word_t got;
    int    n;
    send_frame(row_cmd[i], row_dat[i]);
    wait_busy(1'b1, 20, ok);
    if (!ok) begin
      $display("frame %0d (cmd %h) not taken by %0t, busy never rose", i, row_cmd[i], $time);
      fail_cnt++;
    end else begin
      wait_busy(1'b0, row_cycles, ok);
      if (!ok) begin
        $display("busy stuck high at %0t after frame %0d", $time, i);
        fail_cnt++;
      end else if (row_rpl[i]) begin
        n = 0;
        while (reply_q.size() == 0 && n < reply_wait) begin
          @(negedge sys_clk);
          n++;
        end
        if (reply_q.size() == 0) begin
          $display("no reply to frame %0d (cmd %h) by %0t", i, row_cmd[i], $time);
          fail_cnt++;
        end else begin
          got = reply_q.pop_front();
          if (got !== row_exp[i]) begin
            $display("mismatch at %0t reply_word: got %h expected %h", $time, got, row_exp[i]);
            fail_cnt++;
          end else begin
            pass_cnt++;
          end
        end
      end else begin
        repeat (quiet_wait) @(negedge sys_clk);
        if (reply_q.size() != 0) begin
          $display("unexpected reply %h after cmd %h at %0t", reply_q[0], row_cmd[i], $time);
          fail_cnt++;
          reply_q.delete();
        end else begin
          pass_cnt++;
        end
      end
    end
  endtask

  initial begin
    int limit_ns;
    wait (table_ready);
    limit_ns = row_cmd.size() * row_cycles * 10 + 5000;
    #(limit_ns);
    $display("timeout: run still going after %0d ns", limit_ns);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    int first_fail;
    link_clk   = 1'b0;
    link_bit   = 1'b0;
    link_phase = 0;
    rx_cnt     = 0;
    pass_cnt   = 0;
    fail_cnt   = 0;
    void'($urandom(15));
    build_table();
    table_ready = 1'b1;
    wait (sys_rst_n === 1'b1);
    first_fail = fail_cnt;
    repeat (40) begin  // idle line with nothing sent
      @(negedge sys_clk);
      if (busy !== 1'b0 || reply_bit !== 1'b0) begin
        $display("mismatch at %0t busy/reply_bit: got %b/%b expected 0/0", $time, busy,
                 reply_bit);
        fail_cnt++;
      end else begin
        pass_cnt++;
      end
    end
    $display("test 1 idle after reset: %0s", (fail_cnt == first_fail) ? "ok" : "errors");
    first_fail = fail_cnt;
    for (int i = 0; i < row_cmd.size(); i++) begin
      apply_row(i);
      if (i == row_cmd.size() - 1 || row_grp[i+1] != row_grp[i]) begin
        $display("test %0d %s: %0s", row_grp[i] + 2, grp_name[row_grp[i]],
                 (fail_cnt == first_fail) ? "ok" : "errors");
        first_fail = fail_cnt;
      end
    end
    $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+source
source/host_link_pkg.sv
source/mem_port_if.sv
source/link_frame_rx.sv
source/link_frame_tx.sv
source/cmd_executor.sv
source/block_checksum.sv
source/mem_arbiter.sv
source/word_ram.sv
source/host_link_top.sv
tests/tb_clock_gen.sv
tests/tb_host_link.sv
